// File: rvseed_defines.svh
`ifndef RVSEED_DEFINES_SVH
`define RVSEED_DEFINES_SVH

// request side address width, byte address from fetch or load unit
`define RW_ADDR_WIDTH   32

// axi data bus width, one doubleword per beat
`define AXI_DATA_WIDTH  64

// width of data handed back to the requesters
`define RW_DATA_WIDTH   64

// read id width, id tied to zero
`define AXI_ID_WIDTH    4

// arlen code for a single-beat burst
`define AXI_LEN_SINGLE  8'd0

// arsize code for 8 bytes per beat
`define AXI_SIZE_DW     3'b011

// arburst code for incrementing burst
`define AXI_BURST_INCR  2'b01

`endif

// File: rvseed_pkg.sv
package rvseed_pkg;

    // load access size as encoded by the load unit
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } rw_size_e;

    // owner of the read in flight
    typedef enum logic {
        // instruction fetch
        SRC_IF  = 1'b0,
        // load unit
        SRC_MEM = 1'b1
    } req_src_e;

    // axi read channel state
    typedef enum logic [1:0] {
        // waiting for a new request
        R_IDLE = 2'd0,
        // arvalid up, waiting for arready
        R_ADDR = 2'd1,
        // rready up, waiting for last beat
        R_READ = 2'd2
    } r_state_e;

endpackage

// File: rw_arbiter.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module rw_arbiter (
    input  logic                        clock,
    input  logic                        reset_n,

    // instruction fetch request
    input  logic                        if_valid_i,
    input  logic [`RW_ADDR_WIDTH-1:0]   if_addr_i,

    // load unit request
    input  logic                        mem_valid_i,
    input  logic [`RW_ADDR_WIDTH-1:0]   mem_addr_i,
    input  rvseed_pkg::rw_size_e        mem_size_i,
    input  logic                        mem_unsigned_i,

    // completion from the aligner
    input  logic                        done_i,

    // read request to the axi master
    output logic                        rw_valid_o,
    output logic [`RW_ADDR_WIDTH-1:0]   rw_addr_o,

    // latched access info for the aligner
    output rvseed_pkg::req_src_e        owner_o,
    output rvseed_pkg::rw_size_e        size_o,
    output logic                        unsigned_o,
    output logic [2:0]                  offset_o
);

    // one read in flight at a time
    logic                       busy;
    logic                       grant;
    rvseed_pkg::req_src_e       winner;
    rvseed_pkg::req_src_e       owner_q;
    logic [`RW_ADDR_WIDTH-1:0]  addr_q;
    rvseed_pkg::rw_size_e       size_q;
    logic                       unsigned_q;

    // grant only when idle and someone is asking
    assign grant = ~busy & (if_valid_i | mem_valid_i);

    // fixed priority, load unit beats fetch
    assign winner = mem_valid_i ? rvseed_pkg::SRC_MEM : rvseed_pkg::SRC_IF;

    // busy from grant until the aligner reports done
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            busy <= 1'b0;
        end else if (grant) begin
            busy <= 1'b1;
        end else if (done_i) begin
            busy <= 1'b0;
        end
    end

    // owner of the current read
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            owner_q <= rvseed_pkg::SRC_IF;
        end else if (grant) begin
            owner_q <= winner;
        end
    end

    // winner's address and access mode, held for the whole read
    always_ff @(posedge clock) begin
        if (grant) begin
            if (mem_valid_i) begin
                addr_q     <= mem_addr_i;
                size_q     <= mem_size_i;
                unsigned_q <= mem_unsigned_i;
            end else begin
                // fetch is always a signed 32-bit word
                addr_q     <= if_addr_i;
                size_q     <= rvseed_pkg::SIZE_W;
                unsigned_q <= 1'b0;
            end
        end
    end

    // request level follows busy, rises the edge after grant
    assign rw_valid_o = busy;

    // doubleword aligned address for the bus
    assign rw_addr_o = {addr_q[`RW_ADDR_WIDTH-1:3], 3'b000};

    // byte offset inside the doubleword
    assign offset_o = addr_q[2:0];

    assign owner_o    = owner_q;
    assign size_o     = size_q;
    assign unsigned_o = unsigned_q;

endmodule

// File: axi_read_master.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module axi_read_master (
    input  logic                        clock,
    input  logic                        reset_n,

    // request from the arbiter
    input  logic                        rw_valid_i,
    input  logic [`RW_ADDR_WIDTH-1:0]   rw_addr_i,

    // axi read address channel
    input  logic                        ar_ready_i,
    output logic                        ar_valid_o,
    output logic [`RW_ADDR_WIDTH-1:0]   ar_addr_o,
    output logic [7:0]                  ar_len_o,
    output logic [2:0]                  ar_size_o,
    output logic [1:0]                  ar_burst_o,
    output logic [`AXI_ID_WIDTH-1:0]    ar_id_o,

    // axi read data channel
    output logic                        r_ready_o,
    input  logic                        r_valid_i,
    input  logic [1:0]                  r_resp_i,
    input  logic [`AXI_DATA_WIDTH-1:0]  r_data_i,
    input  logic                        r_last_i,

    // captured beat to the aligner
    output logic [`RW_DATA_WIDTH-1:0]   data_read_o,
    output logic [1:0]                  resp_o,
    output logic                        r_done_o
);

    rvseed_pkg::r_state_e   r_state;
    logic                   rw_valid_q;
    logic                   start;
    logic                   ar_hs;
    logic                   r_hs;
    logic                   r_last_hs;

    // channel handshakes
    assign ar_hs     = ar_valid_o & ar_ready_i;
    assign r_hs      = r_ready_o & r_valid_i;
    assign r_last_hs = r_hs & r_last_i;

    // previous request level, for rise detection
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rw_valid_q <= 1'b0;
        end else begin
            rw_valid_q <= rw_valid_i;
        end
    end

    // a new read starts only on a fresh request level
    // request stays high until the aligner is done, so no restart in between
    assign start = rw_valid_i & ~rw_valid_q;

    // read channel state machine, advances only while requested
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            r_state <= rvseed_pkg::R_IDLE;
        end else if (rw_valid_i) begin
            case (r_state)
                rvseed_pkg::R_IDLE: begin
                    if (start) begin
                        r_state <= rvseed_pkg::R_ADDR;
                    end
                end
                rvseed_pkg::R_ADDR: begin
                    // address accepted
                    if (ar_hs) begin
                        r_state <= rvseed_pkg::R_READ;
                    end
                end
                rvseed_pkg::R_READ: begin
                    // last beat taken
                    if (r_last_hs) begin
                        r_state <= rvseed_pkg::R_IDLE;
                    end
                end
                default: begin
                    r_state <= rvseed_pkg::R_IDLE;
                end
            endcase
        end
    end

    // ar channel, address held by the arbiter until the handshake
    assign ar_valid_o = (r_state == rvseed_pkg::R_ADDR);
    assign ar_addr_o  = rw_addr_i;
    assign ar_len_o   = `AXI_LEN_SINGLE;
    assign ar_size_o  = `AXI_SIZE_DW;
    assign ar_burst_o = `AXI_BURST_INCR;
    assign ar_id_o    = {`AXI_ID_WIDTH{1'b0}};

    // ready for data through the whole read state
    assign r_ready_o = (r_state == rvseed_pkg::R_READ);

    // beat and response captured on every r handshake
    always_ff @(posedge clock) begin
        if (r_hs) begin
            data_read_o <= r_data_i;
            resp_o      <= r_resp_i;
        end
    end

    // done pulse lines up with the captured beat
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            r_done_o <= 1'b0;
        end else begin
            r_done_o <= r_last_hs;
        end
    end

endmodule

// File: load_align.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module load_align (
    input  logic                        clock,
    input  logic                        reset_n,

    // captured beat from the axi master
    input  logic                        r_done_i,
    input  logic [`RW_DATA_WIDTH-1:0]   data_i,
    input  logic [1:0]                  resp_i,

    // access info latched by the arbiter
    input  rvseed_pkg::req_src_e        owner_i,
    input  rvseed_pkg::rw_size_e        size_i,
    input  logic                        unsigned_i,
    input  logic [2:0]                  offset_i,

    // results back to the requesters
    output logic                        if_done_o,
    output logic                        mem_done_o,
    output logic [`RW_DATA_WIDTH-1:0]   if_data_o,
    output logic [`RW_DATA_WIDTH-1:0]   mem_data_o,
    output logic [1:0]                  rresp_o,
    output logic                        done_o
);

    logic [`RW_DATA_WIDTH-1:0]  shifted;
    logic [`RW_DATA_WIDTH-1:0]  aligned;
    logic                       to_mem;

    // addressed byte moved down to bit 0
    assign shifted = data_i >> {offset_i, 3'b000};

    // cut to size, then sign or zero extend
    always_comb begin
        case (size_i)
            rvseed_pkg::SIZE_B: begin
                aligned = {{(`RW_DATA_WIDTH-8){~unsigned_i & shifted[7]}}, shifted[7:0]};
            end
            rvseed_pkg::SIZE_H: begin
                aligned = {{(`RW_DATA_WIDTH-16){~unsigned_i & shifted[15]}}, shifted[15:0]};
            end
            rvseed_pkg::SIZE_W: begin
                aligned = {{(`RW_DATA_WIDTH-32){~unsigned_i & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                aligned = shifted;
            end
        endcase
    end

    assign to_mem = (owner_i == rvseed_pkg::SRC_MEM);

    // result goes only to the owner's data register
    always_ff @(posedge clock) begin
        if (r_done_i) begin
            if (to_mem) begin
                mem_data_o <= aligned;
            end else begin
                if_data_o <= aligned;
            end
            rresp_o <= resp_i;
        end
    end

    // one-cycle done, steered to the owner
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            if_done_o  <= 1'b0;
            mem_done_o <= 1'b0;
        end else begin
            if_done_o  <= r_done_i & ~to_mem;
            mem_done_o <= r_done_i & to_mem;
        end
    end

    // same pulse frees the arbiter
    assign done_o = if_done_o | mem_done_o;

endmodule

// File: rv_axi_read_top.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module rv_axi_read_top (
    input  logic                        clock,
    input  logic                        reset_n,

    // instruction fetch port
    input  logic                        if_valid_i,
    input  logic [`RW_ADDR_WIDTH-1:0]   if_addr_i,
    output logic                        if_done_o,
    output logic [`RW_DATA_WIDTH-1:0]   if_data_o,

    // load unit port
    input  logic                        mem_valid_i,
    input  logic [`RW_ADDR_WIDTH-1:0]   mem_addr_i,
    input  rvseed_pkg::rw_size_e        mem_size_i,
    input  logic                        mem_unsigned_i,
    output logic                        mem_done_o,
    output logic [`RW_DATA_WIDTH-1:0]   mem_data_o,

    // response code, valid with either done
    output logic [1:0]                  rresp_o,

    // axi read address channel
    input  logic                        ar_ready_i,
    output logic                        ar_valid_o,
    output logic [`RW_ADDR_WIDTH-1:0]   ar_addr_o,
    output logic [7:0]                  ar_len_o,
    output logic [2:0]                  ar_size_o,
    output logic [1:0]                  ar_burst_o,
    output logic [`AXI_ID_WIDTH-1:0]    ar_id_o,

    // axi read data channel
    output logic                        r_ready_o,
    input  logic                        r_valid_i,
    input  logic [1:0]                  r_resp_i,
    input  logic [`AXI_DATA_WIDTH-1:0]  r_data_i,
    input  logic                        r_last_i
);

    // arbiter to master
    logic                       rw_valid;
    logic [`RW_ADDR_WIDTH-1:0]  rw_addr;

    // master to aligner
    logic                       r_done;
    logic [`RW_DATA_WIDTH-1:0]  data_read;
    logic [1:0]                 resp;

    // arbiter to aligner, held for the whole read
    rvseed_pkg::req_src_e       owner;
    rvseed_pkg::rw_size_e       size;
    logic                       load_unsigned;
    logic [2:0]                 offset;

    // aligner back to arbiter
    logic                       align_done;

    rw_arbiter u_arbiter (
        .clock          (clock),
        .reset_n        (reset_n),
        .if_valid_i     (if_valid_i),
        .if_addr_i      (if_addr_i),
        .mem_valid_i    (mem_valid_i),
        .mem_addr_i     (mem_addr_i),
        .mem_size_i     (mem_size_i),
        .mem_unsigned_i (mem_unsigned_i),
        .done_i         (align_done),
        .rw_valid_o     (rw_valid),
        .rw_addr_o      (rw_addr),
        .owner_o        (owner),
        .size_o         (size),
        .unsigned_o     (load_unsigned),
        .offset_o       (offset)
    );

    axi_read_master u_master (
        .clock          (clock),
        .reset_n        (reset_n),
        .rw_valid_i     (rw_valid),
        .rw_addr_i      (rw_addr),
        .ar_ready_i     (ar_ready_i),
        .ar_valid_o     (ar_valid_o),
        .ar_addr_o      (ar_addr_o),
        .ar_len_o       (ar_len_o),
        .ar_size_o      (ar_size_o),
        .ar_burst_o     (ar_burst_o),
        .ar_id_o        (ar_id_o),
        .r_ready_o      (r_ready_o),
        .r_valid_i      (r_valid_i),
        .r_resp_i       (r_resp_i),
        .r_data_i       (r_data_i),
        .r_last_i       (r_last_i),
        .data_read_o    (data_read),
        .resp_o         (resp),
        .r_done_o       (r_done)
    );

    load_align u_align (
        .clock          (clock),
        .reset_n        (reset_n),
        .r_done_i       (r_done),
        .data_i         (data_read),
        .resp_i         (resp),
        .owner_i        (owner),
        .size_i         (size),
        .unsigned_i     (load_unsigned),
        .offset_i       (offset),
        .if_done_o      (if_done_o),
        .mem_done_o     (mem_done_o),
        .if_data_o      (if_data_o),
        .mem_data_o     (mem_data_o),
        .rresp_o        (rresp_o),
        .done_o         (align_done)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // reset low for 10 cycles, released on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

// File: tb_axi_mem_slave.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module tb_axi_mem_slave (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        ar_valid_i,
    input  logic [`RW_ADDR_WIDTH-1:0]   ar_addr_i,
    output logic                        ar_ready_o,
    input  logic                        r_ready_i,
    output logic                        r_valid_o,
    output logic [`AXI_DATA_WIDTH-1:0]  r_data_o,
    output logic [1:0]                  r_resp_o,
    output logic                        r_last_o
);

    integer                     seed = 46;
    logic                       have_addr = 1'b0;
    logic [`RW_ADDR_WIDTH-1:0]  addr_q = '0;
    logic [1:0]                 ar_cnt = 2'd0;
    logic [1:0]                 r_cnt = 2'd0;

    // memory rule, byte at a is a*7+3 mod 256
    function automatic logic [7:0] byte_at(input logic [31:0] a);
        logic [31:0] t;
        t = a * 32'd7 + 32'd3;
        return t[7:0];
    endfunction

    // 0 to 3 cycles of stall
    function automatic logic [1:0] draw_delay();
        integer v;
        v = $random(seed);
        return v[1:0];
    endfunction

    // ready once the address stall has run out
    assign ar_ready_o = ~have_addr & (ar_cnt == 2'd0);
    assign r_valid_o  = have_addr & (r_cnt == 2'd0);
    // single beat, so every beat is the last
    assign r_last_o   = r_valid_o;
    // upper half of the map answers slverr
    assign r_resp_o   = addr_q[31] ? 2'b10 : 2'b00;

    genvar g;
    generate
        for (g = 0; g < 8; g++) begin : g_bytes
            assign r_data_o[8*g +: 8] = byte_at(addr_q + g);
        end
    endgenerate

    always @(posedge clock) begin
        if (!reset_n) begin
            have_addr <= 1'b0;
            addr_q    <= '0;
            ar_cnt    <= 2'd0;
            r_cnt     <= 2'd0;
        end else if (!have_addr) begin
            if (ar_valid_i && ar_ready_o) begin
                have_addr <= 1'b1;
                addr_q    <= ar_addr_i;
                r_cnt     <= draw_delay();
            end else if (ar_valid_i && ar_cnt != 2'd0) begin
                ar_cnt <= ar_cnt - 2'd1;
            end
        end else if (r_valid_o && r_ready_i) begin
            // beat taken, next address gets a fresh stall
            have_addr <= 1'b0;
            ar_cnt    <= draw_delay();
        end else if (r_cnt != 2'd0) begin
            r_cnt <= r_cnt - 2'd1;
        end
    end

endmodule

// File: tb_rv_axi_read.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module tb_rv_axi_read;

    logic                       clock;
    logic                       reset_n;
    logic                       if_valid;
    logic [`RW_ADDR_WIDTH-1:0]  if_addr;
    logic                       if_done;
    logic [`RW_DATA_WIDTH-1:0]  if_data;
    logic                       mem_valid;
    logic [`RW_ADDR_WIDTH-1:0]  mem_addr;
    rvseed_pkg::rw_size_e       mem_size;
    logic                       mem_unsigned;
    logic                       mem_done;
    logic [`RW_DATA_WIDTH-1:0]  mem_data;
    logic [1:0]                 rresp;
    logic                       ar_valid;
    logic                       ar_ready;
    logic [`RW_ADDR_WIDTH-1:0]  ar_addr;
    logic [7:0]                 ar_len;
    logic [2:0]                 ar_size;
    logic [1:0]                 ar_burst;
    logic [`AXI_ID_WIDTH-1:0]   ar_id;
    logic                       r_ready;
    logic                       r_valid;
    logic [1:0]                 r_resp;
    logic [`AXI_DATA_WIDTH-1:0] r_data;
    logic                       r_last;

    int mismatches = 0;
    int failures = 0;

    // stimulus table with one entry per row
    bit                         tab_if_v[$];
    logic [31:0]                tab_if_addr[$];
    bit                         tab_mem_v[$];
    logic [31:0]                tab_mem_addr[$];
    rvseed_pkg::rw_size_e       tab_size[$];
    bit                         tab_uns[$];

    tb_clock_gen u_clock (.clock(clock), .reset_n(reset_n));

    tb_axi_mem_slave u_slave (
        .clock(clock), .reset_n(reset_n),
        .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_ready_o(ar_ready),
        .r_ready_i(r_ready), .r_valid_o(r_valid), .r_data_o(r_data),
        .r_resp_o(r_resp), .r_last_o(r_last)
    );

    rv_axi_read_top dut (
        .clock(clock), .reset_n(reset_n),
        .if_valid_i(if_valid), .if_addr_i(if_addr), .if_done_o(if_done), .if_data_o(if_data),
        .mem_valid_i(mem_valid), .mem_addr_i(mem_addr), .mem_size_i(mem_size),
        .mem_unsigned_i(mem_unsigned), .mem_done_o(mem_done), .mem_data_o(mem_data),
        .rresp_o(rresp),
        .ar_ready_i(ar_ready), .ar_valid_o(ar_valid), .ar_addr_o(ar_addr), .ar_len_o(ar_len),
        .ar_size_o(ar_size), .ar_burst_o(ar_burst), .ar_id_o(ar_id),
        .r_ready_o(r_ready), .r_valid_i(r_valid), .r_resp_i(r_resp), .r_data_i(r_data),
        .r_last_i(r_last)
    );

    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        logic [31:0] t;
        t = a * 32'd7 + 32'd3;
        return t[7:0];
    endfunction

    // field as a load of this size should see it
    function automatic logic [63:0] field_value(input logic [31:0] addr,
                                                input rvseed_pkg::rw_size_e size,
                                                input bit is_unsigned);
        logic [63:0] val;
        int nbytes;
        int i;
        val = '0;
        nbytes = 1 << size;
        // bytes past the doubleword end are missing and read as zero
        for (i = 0; i < nbytes; i++) begin
            if (int'(addr[2:0]) + i < 8) begin
                val[8*i +: 8] = mem_byte(addr + i);
            end
        end
        if (!is_unsigned && nbytes < 8 && val[8*nbytes-1]) begin
            val = val | ({64{1'b1}} << (8 * nbytes));
        end
        return val;
    endfunction

    function automatic logic [1:0] resp_for(input logic [31:0] addr);
        return (addr >= 32'h8000_0000) ? 2'b10 : 2'b00;
    endfunction

    task automatic add_row(input bit ifv, input logic [31:0] ifa, input bit memv,
                           input logic [31:0] mema, input rvseed_pkg::rw_size_e sz,
                           input bit uns);
        tab_if_v.push_back(ifv);
        tab_if_addr.push_back(ifa);
        tab_mem_v.push_back(memv);
        tab_mem_addr.push_back(mema);
        tab_size.push_back(sz);
        tab_uns.push_back(uns);
    endtask

    task automatic compare_value(input string what, input int r,
                                 input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t: row %0d %s got %h, expected %h",
                     $time, r, what, got, want);
            mismatches++;
        end
    endtask

    // no done, no address phase and no data ready while nothing is requested
    task automatic check_quiet(input int r, input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            if (if_done || mem_done || ar_valid || r_ready) begin
                $display("row %0d: unexpected done, ar_valid or r_ready at %0t while idle",
                         r, $time);
                failures++;
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [63:0] want_if;
        logic [63:0] want_mem;
        bit if_open;
        bit mem_open;
        int cycles;
        want_if  = field_value(tab_if_addr[r], rvseed_pkg::SIZE_W, 1'b0);
        want_mem = field_value(tab_mem_addr[r], tab_size[r], tab_uns[r]);
        if_open  = tab_if_v[r];
        mem_open = tab_mem_v[r];
        cycles   = 0;
        if_valid     = tab_if_v[r];
        if_addr      = tab_if_addr[r];
        mem_valid    = tab_mem_v[r];
        mem_addr     = tab_mem_addr[r];
        mem_size     = tab_size[r];
        mem_unsigned = tab_uns[r];
        while ((if_open || mem_open) && cycles < 40) begin
            @(negedge clock);
            cycles++;
            if (mem_done && !mem_open) begin
                $display("row %0d: load done without a pending load at %0t", r, $time);
                failures++;
            end else if (mem_done) begin
                compare_value("load data", r, mem_data, want_mem);
                compare_value("load resp", r, rresp, resp_for(tab_mem_addr[r]));
                mem_open  = 0;
                mem_valid = 1'b0;
            end
            if (if_done && (!if_open || mem_open)) begin
                $display("row %0d: fetch done out of turn at %0t", r, $time);
                failures++;
            end else if (if_done) begin
                compare_value("fetch data", r, if_data, want_if);
                compare_value("fetch resp", r, rresp, resp_for(tab_if_addr[r]));
                if_open  = 0;
                if_valid = 1'b0;
            end
        end
        if (if_open || mem_open) begin
            $display("row %0d: done pulse never came (fetch %0b, load %0b)", r, if_open, mem_open);
            failures++;
        end
        if_valid  = 1'b0;
        mem_valid = 1'b0;
        check_quiet(r, 3);
    endtask

    // every address phase is one aligned doubleword beat with id zero
    always @(negedge clock) begin
        if (reset_n && ar_valid && ar_ready) begin
            if (ar_addr[2:0] != 3'b000 || ar_len != 8'd0 || ar_size != 3'b011 ||
                ar_burst != 2'b01 || ar_id != '0) begin
                $display("Mismatch at %0t: AR addr %h len %0d size %0d burst %0d id %0d",
                         $time, ar_addr, ar_len, ar_size, ar_burst, ar_id);
                mismatches++;
            end
        end
    end

    // watchdog allows 40 cycles per row plus reset
    initial begin
        longint limit;
        rvseed_pkg::r_state_e st;
        #1;
        limit = (tab_if_v.size() * 40 + 20) * 100;
        #(limit);
        st = dut.u_master.r_state;
        $display("timeout at %0t, read master stuck in %s", $time, st.name());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        if_valid     = 1'b0;
        if_addr      = '0;
        mem_valid    = 1'b0;
        mem_addr     = '0;
        mem_size     = rvseed_pkg::SIZE_B;
        mem_unsigned = 1'b0;
        // fetch only
        add_row(1, 32'h0000_0100, 0, 32'h0000_0000, rvseed_pkg::SIZE_B, 0);
        add_row(1, 32'h0000_0110, 0, 32'h0000_0000, rvseed_pkg::SIZE_B, 0);
        add_row(1, 32'h0000_1f3c, 0, 32'h0000_0000, rvseed_pkg::SIZE_B, 0);
        // loads of each size at several offsets
        add_row(0, 32'h0000_0000, 1, 32'h0000_0200, rvseed_pkg::SIZE_B, 0);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0212, rvseed_pkg::SIZE_B, 0);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0213, rvseed_pkg::SIZE_B, 1);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0207, rvseed_pkg::SIZE_B, 0);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0312, rvseed_pkg::SIZE_H, 0);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0312, rvseed_pkg::SIZE_H, 1);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0306, rvseed_pkg::SIZE_H, 0);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0410, rvseed_pkg::SIZE_W, 0);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0414, rvseed_pkg::SIZE_W, 1);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0508, rvseed_pkg::SIZE_D, 0);
        add_row(0, 32'h0000_0000, 1, 32'h0000_0a18, rvseed_pkg::SIZE_D, 1);
        // misaligned word with upper bytes missing
        add_row(0, 32'h0000_0000, 1, 32'h0000_0a06, rvseed_pkg::SIZE_W, 0);
        // both valid and load served first
        add_row(1, 32'h0000_0600, 1, 32'h0000_0623, rvseed_pkg::SIZE_B, 0);
        add_row(1, 32'h0000_0704, 1, 32'h0000_0714, rvseed_pkg::SIZE_W, 1);
        add_row(1, 32'h0000_0810, 1, 32'h0000_0820, rvseed_pkg::SIZE_D, 0);
        add_row(1, 32'h0000_0c0c, 1, 32'h0000_0b01, rvseed_pkg::SIZE_H, 1);
        // slverr region
        add_row(0, 32'h0000_0000, 1, 32'h8000_0010, rvseed_pkg::SIZE_W, 0);
        add_row(1, 32'hffff_fffc, 0, 32'h0000_0000, rvseed_pkg::SIZE_B, 0);
        add_row(1, 32'h0000_0900, 1, 32'h9000_0001, rvseed_pkg::SIZE_B, 0);
        wait (reset_n === 1'b1);
        check_quiet(-1, 5);
        for (int r = 0; r < tab_if_v.size(); r++) begin
            run_row(r);
        end
        $display("summary: %0d mismatches, %0d other errors over %0d rows",
                 mismatches, failures, tab_if_v.size());
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
rvseed_pkg.sv
rw_arbiter.sv
axi_read_master.sv
load_align.sv
rv_axi_read_top.sv
tb_clock_gen.sv
tb_axi_mem_slave.sv
tb_rv_axi_read.sv
